// ==== hdl/id_pkg.sv ====
package id_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] imm12_t;
  typedef logic [2:0]  funct3_t;

  typedef enum logic [3:0] {
    cls_none,
    cls_op_imm,
    cls_op_imm_w,
    cls_op,
    cls_op_w,
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store
  } inst_class_e;

  // W variants reuse the 64-bit codes, EX tells them apart by class
  typedef enum logic [4:0] {
    alu_nop,
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_beq,
    alu_bne,
    alu_blt,
    alu_bge,
    alu_bltu,
    alu_bgeu
  } alu_op_e;

  // write port of a later stage
  typedef struct packed {
    logic      ena;
    reg_addr_t addr;
    xlen_t     data;
  } fwd_t;

  typedef struct packed {
    inst_class_e cls;
    alu_op_e     alu_op;
    logic        rs1_read;
    logic        rs2_read;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic        rd_w_ena;
    reg_addr_t   rd;
    xlen_t       imm_i;
    xlen_t       imm_u;
    imm12_t      mem_offset;
    funct3_t     mem_funct3;
  } dec_t;

  typedef struct packed {
    inst_class_e cls;
    alu_op_e     alu_op;
    xlen_t       op1;
    xlen_t       op2;
    logic        rd_w_ena;
    reg_addr_t   rd;
    xlen_t       pc;
    imm12_t      mem_offset;
    funct3_t     mem_funct3;
  } id_ex_t;

  localparam id_ex_t id_ex_bubble = '{cls: cls_none, alu_op: alu_nop, default: '0};

endpackage

// ==== hdl/id_inst_decoder.sv ====
`timescale 1ns/1ns

module id_inst_decoder (
  input  id_pkg::inst_t inst_i,
  output id_pkg::dec_t  dec_o
);

  import id_pkg::*;

  // major opcodes, bits 6:2
  localparam logic [4:0] opc_load     = 5'b00000;
  localparam logic [4:0] opc_op_imm   = 5'b00100;
  localparam logic [4:0] opc_auipc    = 5'b00101;
  localparam logic [4:0] opc_op_imm_w = 5'b00110;
  localparam logic [4:0] opc_store    = 5'b01000;
  localparam logic [4:0] opc_op       = 5'b01100;
  localparam logic [4:0] opc_lui      = 5'b01101;
  localparam logic [4:0] opc_op_w     = 5'b01110;
  localparam logic [4:0] opc_branch   = 5'b11000;
  localparam logic [4:0] opc_jalr     = 5'b11001;
  localparam logic [4:0] opc_jal      = 5'b11011;

  logic [6:0]  opcode;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  funct3_t     funct3;
  logic [6:0]  funct7;
  imm12_t      imm_i;
  imm12_t      imm_s;
  logic [19:0] imm_u;
  logic        shamt_ok;
  logic        f7_ok;
  logic        w_f3_ok;
  inst_class_e cls;
  alu_op_e     alu_op;
  logic        rs1_read;
  logic        rs2_read;
  logic        rd_w_ena;

  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  assign funct7 = inst_i[31:25];
  assign imm_i  = inst_i[31:20];
  assign imm_s  = {inst_i[31:25], inst_i[11:7]};
  assign imm_u  = inst_i[31:12];

  // 6-bit shamt, bit 30 only for srai
  assign shamt_ok = ({inst_i[31], inst_i[29:26]} == 5'b0) && (funct3[2] || !inst_i[30]);
  // funct7 is 0000000, or 0100000 for sub and sra; rejects the M extension
  assign f7_ok    = ({funct7[6], funct7[4:0]} == 6'b0) &&
                    (!funct7[5] || funct3 == 3'b000 || funct3 == 3'b101);
  assign w_f3_ok  = funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101;

  function automatic alu_op_e arith_op(funct3_t f3, logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic alu_op_e branch_op(funct3_t f3);
    case (f3)
      3'b000:  return alu_beq;
      3'b001:  return alu_bne;
      3'b100:  return alu_blt;
      3'b101:  return alu_bge;
      3'b110:  return alu_bltu;
      3'b111:  return alu_bgeu;
      default: return alu_nop;
    endcase
  endfunction

  always_comb begin
    cls    = cls_none;
    alu_op = alu_nop;
    case (opcode[6:2])
      opc_op_imm: begin
        if (funct3[1:0] != 2'b01 || shamt_ok) begin
          cls    = cls_op_imm;
          alu_op = arith_op(funct3, funct3 == 3'b101 && inst_i[30]);
        end
      end
      opc_op_imm_w: begin
        if (funct3 == 3'b000 || (w_f3_ok && f7_ok)) begin
          cls    = cls_op_imm_w;
          alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
        end
      end
      opc_op: begin
        if (f7_ok) begin
          cls    = cls_op;
          alu_op = arith_op(funct3, funct7[5]);
        end
      end
      opc_op_w: begin
        if (w_f3_ok && f7_ok) begin
          cls    = cls_op_w;
          alu_op = arith_op(funct3, funct7[5]);
        end
      end
      opc_lui: begin
        cls    = cls_lui;
        alu_op = alu_add;
      end
      opc_auipc: begin
        cls    = cls_auipc;
        alu_op = alu_add;
      end
      opc_jal: begin
        cls    = cls_jal;
        alu_op = alu_add;
      end
      opc_jalr: begin
        if (funct3 == 3'b000) begin
          cls    = cls_jalr;
          alu_op = alu_add;
        end
      end
      opc_branch: begin
        if (funct3[2:1] != 2'b01) begin
          cls    = cls_branch;
          alu_op = branch_op(funct3);
        end
      end
      opc_load: begin
        if (opcode[1:0] == 2'b11 && funct3 != 3'b111) begin
          cls    = cls_load;
          alu_op = alu_add;
        end
      end
      opc_store: begin
        if (!funct3[2]) begin
          cls    = cls_store;
          alu_op = alu_add;
        end
      end
      default: begin
      end
    endcase
  end

  assign rs1_read = cls inside {cls_op_imm, cls_op_imm_w, cls_op, cls_op_w,
                                cls_branch, cls_load, cls_store, cls_jalr};
  assign rs2_read = cls inside {cls_op, cls_op_w, cls_branch, cls_store};
  assign rd_w_ena = (rd != '0) && (cls inside {cls_op_imm, cls_op_imm_w, cls_op, cls_op_w,
                                               cls_load, cls_lui, cls_auipc, cls_jal, cls_jalr});

  assign dec_o = '{
    cls:        cls,
    alu_op:     alu_op,
    rs1_read:   rs1_read,
    rs2_read:   rs2_read,
    rs1:        rs1,
    rs2:        rs2,
    rd_w_ena:   rd_w_ena,
    rd:         rd_w_ena ? rd : '0,
    imm_i:      {{52{imm_i[11]}}, imm_i},
    imm_u:      {{44{imm_u[19]}}, imm_u},
    mem_offset: (cls == cls_load) ? imm_i : ((cls == cls_store) ? imm_s : '0),
    mem_funct3: (cls == cls_load || cls == cls_store) ? funct3 : '0
  };

  // legality filters and op tables must agree on what is decoded
  always_comb begin
    assert final ((dec_o.cls == cls_none) == (dec_o.alu_op == alu_nop))
      else $error("decoded class and ALU operation disagree");
  end

endmodule

// ==== hdl/id_operand_sel.sv ====
`timescale 1ns/1ns

module id_operand_sel (
  input  logic              reset_i,
  input  id_pkg::dec_t      dec_i,
  input  id_pkg::xlen_t     pc_i,
  input  id_pkg::xlen_t     rf_rdata1_i,
  input  id_pkg::xlen_t     rf_rdata2_i,
  input  id_pkg::fwd_t      ex_fwd_i,
  input  id_pkg::fwd_t      mem_fwd_i,
  input  logic              ex_load_i,
  input  logic              wb_rd_ena_i,
  input  id_pkg::reg_addr_t wb_rd_addr_i,
  output id_pkg::reg_addr_t rf_raddr1_o,
  output id_pkg::reg_addr_t rf_raddr2_o,
  output logic              stall_o,
  output logic              jalr_redirect_o,
  output id_pkg::xlen_t     jalr_pc_o,
  output id_pkg::id_ex_t    id_ex_o
);

  import id_pkg::*;

  logic  ex_hit1;
  logic  ex_hit2;
  logic  mem_hit1;
  logic  mem_hit2;
  logic  wb_hit1;
  logic  is_jalr;
  xlen_t op1;
  xlen_t op2;
  xlen_t jalr_sum;

  // x0 is never forwarded
  function automatic logic fwd_hit(fwd_t fwd, reg_addr_t raddr);
    return fwd.ena && (fwd.addr == raddr) && (raddr != '0);
  endfunction

  assign rf_raddr1_o = dec_i.rs1_read ? dec_i.rs1 : '0;
  assign rf_raddr2_o = dec_i.rs2_read ? dec_i.rs2 : '0;

  assign ex_hit1  = fwd_hit(ex_fwd_i, rf_raddr1_o);
  assign ex_hit2  = fwd_hit(ex_fwd_i, rf_raddr2_o);
  assign mem_hit1 = fwd_hit(mem_fwd_i, rf_raddr1_o);
  assign mem_hit2 = fwd_hit(mem_fwd_i, rf_raddr2_o);
  assign wb_hit1  = wb_rd_ena_i && (wb_rd_addr_i == rf_raddr1_o) && (rf_raddr1_o != '0);

  // EX is the youngest result and wins over MEM
  always_comb begin
    if (dec_i.rs1_read) begin
      op1 = ex_hit1 ? ex_fwd_i.data : (mem_hit1 ? mem_fwd_i.data : rf_rdata1_i);
    end else if (dec_i.cls == cls_auipc || dec_i.cls == cls_jal) begin
      op1 = pc_i;
    end else begin
      op1 = '0;
    end
  end

  always_comb begin
    if (dec_i.rs2_read) begin
      op2 = ex_hit2 ? ex_fwd_i.data : (mem_hit2 ? mem_fwd_i.data : rf_rdata2_i);
    end else if (dec_i.cls == cls_op_imm || dec_i.cls == cls_op_imm_w) begin
      op2 = dec_i.imm_i;
    end else if (dec_i.cls == cls_lui || dec_i.cls == cls_auipc) begin
      op2 = dec_i.imm_u;
    end else if (dec_i.cls == cls_jal || dec_i.cls == cls_jalr) begin
      op2 = pc_i;
    end else begin
      op2 = '0;
    end
  end

  // load data is not ready until MEM
  assign stall_o = !reset_i && ex_load_i && (ex_hit1 || ex_hit2);

  // a recently written base register makes the fetch-side target stale
  assign is_jalr         = dec_i.cls == cls_jalr;
  assign jalr_sum        = dec_i.imm_i + op1;
  assign jalr_redirect_o = !reset_i && is_jalr && (ex_hit1 || mem_hit1 || wb_hit1);
  assign jalr_pc_o       = is_jalr ? {jalr_sum[63:1], 1'b0} : '0;

  assign id_ex_o = '{
    cls:        dec_i.cls,
    alu_op:     dec_i.alu_op,
    op1:        op1,
    op2:        op2,
    rd_w_ena:   dec_i.rd_w_ena,
    rd:         dec_i.rd,
    pc:         pc_i,
    mem_offset: dec_i.mem_offset,
    mem_funct3: dec_i.mem_funct3
  };

  always_comb begin
    assert final (!stall_o || (dec_i.rs1_read && dec_i.rs1 == ex_fwd_i.addr) ||
                  (dec_i.rs2_read && dec_i.rs2 == ex_fwd_i.addr))
      else $error("stall without a matching read source");
    assert final (!jalr_redirect_o || (is_jalr && dec_i.rs1 != '0))
      else $error("jalr redirect on x0 or on a non-jalr instruction");
  end

endmodule

// ==== hdl/id_ex_reg.sv ====
`timescale 1ns/1ns

module id_ex_reg (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           stall_i,
  input  logic           flush_i,
  input  id_pkg::id_ex_t d_i,
  output id_pkg::id_ex_t q_o
);

  import id_pkg::*;

  logic bubble;

  // a stalled instruction stays in ID, so EX gets a bubble
  assign bubble = reset_i || stall_i || flush_i;

  always_ff @(posedge clk_i) begin
    if (bubble) begin
      q_o <= id_ex_bubble;
    end else begin
      q_o <= d_i;
    end
  end

  // no write and no class may leak into EX behind a stall or flush
  a_bubble_after_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (stall_i || flush_i) |=> (!q_o.rd_w_ena && q_o.cls == cls_none)
  ) else $error("id_ex register did not take a bubble");

endmodule

// ==== hdl/id_stage.sv ====
`timescale 1ns/1ns

module id_stage (
  input  logic              clk_i,
  input  logic              reset_i,
  input  id_pkg::inst_t     inst_i,
  input  id_pkg::xlen_t     pc_i,
  input  id_pkg::xlen_t     rf_rdata1_i,
  input  id_pkg::xlen_t     rf_rdata2_i,
  input  id_pkg::fwd_t      ex_fwd_i,
  input  id_pkg::fwd_t      mem_fwd_i,
  input  logic              ex_load_i,
  input  logic              wb_rd_ena_i,
  input  id_pkg::reg_addr_t wb_rd_addr_i,
  input  logic              flush_i,
  output id_pkg::reg_addr_t rf_raddr1_o,
  output id_pkg::reg_addr_t rf_raddr2_o,
  output logic              stall_o,
  output logic              jalr_redirect_o,
  output id_pkg::xlen_t     jalr_pc_o,
  output id_pkg::id_ex_t    id_ex_o
);

  import id_pkg::*;

  dec_t   dec;
  id_ex_t id_ex_next;

  id_inst_decoder dec0 (
    .inst_i (inst_i),
    .dec_o  (dec)
  );

  id_operand_sel opsel0 (
    .reset_i         (reset_i),
    .dec_i           (dec),
    .pc_i            (pc_i),
    .rf_rdata1_i     (rf_rdata1_i),
    .rf_rdata2_i     (rf_rdata2_i),
    .ex_fwd_i        (ex_fwd_i),
    .mem_fwd_i       (mem_fwd_i),
    .ex_load_i       (ex_load_i),
    .wb_rd_ena_i     (wb_rd_ena_i),
    .wb_rd_addr_i    (wb_rd_addr_i),
    .rf_raddr1_o     (rf_raddr1_o),
    .rf_raddr2_o     (rf_raddr2_o),
    .stall_o         (stall_o),
    .jalr_redirect_o (jalr_redirect_o),
    .jalr_pc_o       (jalr_pc_o),
    .id_ex_o         (id_ex_next)
  );

  id_ex_reg idex0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .stall_i (stall_o),
    .flush_i (flush_i),
    .d_i     (id_ex_next),
    .q_o     (id_ex_o)
  );

endmodule

// ==== dv/tb_id_stage.sv ====
`timescale 1ns/1ns

module tb_id_stage;

  import id_pkg::*;

  localparam int n_tests = 400;
  localparam int n_reset = 16;

  typedef struct packed {
    id_ex_t    bundle;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      stall;
    logic      redirect;
    xlen_t     jalr_pc;
  } expect_t;

  logic      clk = 1'b0;
  logic      reset;
  inst_t     inst;
  xlen_t     pc;
  xlen_t     rf_rdata1;
  xlen_t     rf_rdata2;
  fwd_t      ex_fwd;
  fwd_t      mem_fwd;
  logic      ex_load;
  logic      wb_rd_ena;
  reg_addr_t wb_rd_addr;
  logic      flush;
  reg_addr_t rf_raddr1;
  reg_addr_t rf_raddr2;
  logic      stall;
  logic      jalr_redirect;
  xlen_t     jalr_pc;
  id_ex_t    id_ex;

  integer  seed = 32'h2e75ec6c;
  int      err_count = 0;
  int      n_checks = 0;
  int      n_stall = 0;
  int      n_redirect = 0;
  expect_t exp_q[$];

  id_stage dut0 (
    .clk_i           (clk),
    .reset_i         (reset),
    .inst_i          (inst),
    .pc_i            (pc),
    .rf_rdata1_i     (rf_rdata1),
    .rf_rdata2_i     (rf_rdata2),
    .ex_fwd_i        (ex_fwd),
    .mem_fwd_i       (mem_fwd),
    .ex_load_i       (ex_load),
    .wb_rd_ena_i     (wb_rd_ena),
    .wb_rd_addr_i    (wb_rd_addr),
    .flush_i         (flush),
    .rf_raddr1_o     (rf_raddr1),
    .rf_raddr2_o     (rf_raddr2),
    .stall_o         (stall),
    .jalr_redirect_o (jalr_redirect),
    .jalr_pc_o       (jalr_pc),
    .id_ex_o         (id_ex)
  );

  always #2 clk = ~clk;

  // register file contents, x0 reads zero
  function automatic xlen_t rf_value(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    return {8{addr, 3'b011}} ^ 64'hc3a5_0f96_3c5a_f069;
  endfunction

  // all fields zero, no class and no ALU operation
  function automatic id_ex_t empty_bundle();
    id_ex_t b;
    b = '0;
    b.cls = cls_none;
    b.alu_op = alu_nop;
    return b;
  endfunction

  function automatic logic writes_reg(fwd_t f, reg_addr_t a);
    return f.ena && (f.addr == a) && (a != '0);
  endfunction

  function automatic xlen_t forwarded_value(fwd_t ex, fwd_t mem, reg_addr_t a);
    if (writes_reg(ex, a)) begin
      return ex.data;
    end else if (writes_reg(mem, a)) begin
      return mem.data;
    end
    return rf_value(a);
  endfunction

  function automatic expect_t ref_decode(inst_t ins, xlen_t pcv, fwd_t ex, fwd_t mem,
                                         logic ld, logic wb_ena, reg_addr_t wb_addr,
                                         logic in_reset);
    expect_t     e;
    inst_class_e cls;
    alu_op_e     op;
    funct3_t     f3;
    logic [6:0]  f7;
    logic        alt7;
    logic        alt;
    logic        rd1;
    logic        rd2;
    reg_addr_t   rs1;
    xlen_t       imm_i;
    xlen_t       imm_u;
    e = '0;
    f3 = ins[14:12];
    f7 = ins[31:25];
    rs1 = ins[19:15];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_u = {{44{ins[31]}}, ins[31:12]};
    alt7 = (f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5);
    case (ins[6:0])
      7'b0010011: cls = (f3[1:0] != 2'b01 || ins[31:26] == 6'h00 ||
                         (f3 == 3'd5 && ins[31:26] == 6'h10)) ? cls_op_imm : cls_none;
      7'b0011011: cls = (f3 == 3'd0 || ((f7 == 7'h00 || alt7) && f3 inside {3'd1, 3'd5}))
                        ? cls_op_imm_w : cls_none;
      7'b0110011: cls = (f7 == 7'h00 || alt7) ? cls_op : cls_none;
      7'b0111011: cls = ((f7 == 7'h00 || alt7) && f3 inside {3'd0, 3'd1, 3'd5})
                        ? cls_op_w : cls_none;
      7'b0110111: cls = cls_lui;
      7'b0010111: cls = cls_auipc;
      7'b1101111: cls = cls_jal;
      7'b1100111: cls = (f3 == 3'd0) ? cls_jalr : cls_none;
      7'b1100011: cls = (f3[2:1] != 2'b01) ? cls_branch : cls_none;
      7'b0000011: cls = (f3 != 3'd7) ? cls_load : cls_none;
      7'b0100011: cls = !f3[2] ? cls_store : cls_none;
      default:    cls = cls_none;
    endcase
    // bit 30 selects sub only for register-register forms
    alt = ins[30] && (f3 == 3'd5 || cls inside {cls_op, cls_op_w});
    if (cls inside {cls_op_imm, cls_op_imm_w, cls_op, cls_op_w}) begin
      case (f3)
        3'd0:    op = alt ? alu_sub : alu_add;
        3'd1:    op = alu_sll;
        3'd2:    op = alu_slt;
        3'd3:    op = alu_sltu;
        3'd4:    op = alu_xor;
        3'd5:    op = alt ? alu_sra : alu_srl;
        3'd6:    op = alu_or;
        default: op = alu_and;
      endcase
    end else if (cls == cls_branch) begin
      case (f3)
        3'd0:    op = alu_beq;
        3'd1:    op = alu_bne;
        3'd4:    op = alu_blt;
        3'd5:    op = alu_bge;
        3'd6:    op = alu_bltu;
        default: op = alu_bgeu;
      endcase
    end else begin
      op = (cls == cls_none) ? alu_nop : alu_add;
    end
    rd1 = cls inside {cls_op_imm, cls_op_imm_w, cls_op, cls_op_w,
                      cls_branch, cls_load, cls_store, cls_jalr};
    rd2 = cls inside {cls_op, cls_op_w, cls_branch, cls_store};
    e.raddr1 = rd1 ? rs1 : '0;
    e.raddr2 = rd2 ? ins[24:20] : '0;
    e.bundle.cls = cls;
    e.bundle.alu_op = op;
    if (rd1) begin
      e.bundle.op1 = forwarded_value(ex, mem, rs1);
    end else begin
      e.bundle.op1 = (cls inside {cls_auipc, cls_jal}) ? pcv : '0;
    end
    if (rd2) begin
      e.bundle.op2 = forwarded_value(ex, mem, ins[24:20]);
    end else if (cls inside {cls_op_imm, cls_op_imm_w}) begin
      e.bundle.op2 = imm_i;
    end else if (cls inside {cls_lui, cls_auipc}) begin
      e.bundle.op2 = imm_u;
    end else begin
      e.bundle.op2 = (cls inside {cls_jal, cls_jalr}) ? pcv : '0;
    end
    e.bundle.rd_w_ena = (ins[11:7] != '0) && !(cls inside {cls_none, cls_branch, cls_store});
    e.bundle.rd = e.bundle.rd_w_ena ? ins[11:7] : '0;
    e.bundle.pc = pcv;
    e.bundle.mem_offset = (cls == cls_load) ? ins[31:20] :
                          ((cls == cls_store) ? {ins[31:25], ins[11:7]} : '0);
    e.bundle.mem_funct3 = (cls inside {cls_load, cls_store}) ? f3 : '0;
    e.stall = !in_reset && ld && (writes_reg(ex, e.raddr1) || writes_reg(ex, e.raddr2));
    e.redirect = !in_reset && cls == cls_jalr && (writes_reg(ex, rs1) ||
                 writes_reg(mem, rs1) || (wb_ena && wb_addr == rs1 && rs1 != '0));
    e.jalr_pc = (cls == cls_jalr) ? ((imm_i + e.bundle.op1) & ~64'd1) : '0;
    return e;
  endfunction

  // legal encodings of each kept class, plus M-extension, system and undefined opcodes
  task automatic make_inst(output inst_t ins);
    logic [31:0] r;
    logic [31:0] f;
    int          kind;
    r = $random(seed);
    f = $random(seed);
    kind = $unsigned($random(seed)) % 14;
    ins = r;
    case (kind)
      0: begin
        ins[6:0] = 7'b0010011;
        if (ins[13:12] == 2'b01) ins[31:26] = {1'b0, f[0] & ins[14], 4'b0};
      end
      1, 3: begin
        ins[6:0] = (kind == 1) ? 7'b0011011 : 7'b0111011;
        ins[14:12] = (f[2:1] == 2'd0) ? 3'd1 : ((f[2:1] == 2'd1) ? 3'd5 : 3'd0);
        ins[31:25] = {1'b0, f[3] & (ins[14:12] != 3'd1), 5'b0};
      end
      2: begin
        ins[6:0] = 7'b0110011;
        ins[31:25] = {1'b0, f[3] & (ins[14:12] == 3'd0 || ins[14:12] == 3'd5), 5'b0};
      end
      4: ins[6:0] = 7'b0110111;
      5: ins[6:0] = 7'b0010111;
      6: ins[6:0] = 7'b1101111;
      7: ins = {ins[31:15], 3'b000, ins[11:7], 7'b1100111};
      8: begin
        ins[6:0] = 7'b1100011;
        if (ins[14:13] == 2'b01) ins[14] = 1'b1;
      end
      9: begin
        ins[6:0] = 7'b0000011;
        if (ins[14:12] == 3'd7) ins[12] = 1'b0;
      end
      10: ins = {ins[31:15], 1'b0, ins[13:7], 7'b0100011};
      11: ins = {7'b0000001, ins[24:7], f[0] ? 7'b0110011 : 7'b0111011};
      12: ins[6:0] = 7'b1110011;
      default: ins[6:0] = f[0] ? 7'b0001011 : 7'b0000001;
    endcase
    if (f[7:5] == 3'd0) ins[11:7] = '0;
  endtask

  // write port aimed at rs1, rs2 or a random register
  task automatic make_fwd(input inst_t ins, output fwd_t fw);
    logic [31:0] r;
    r = $random(seed);
    fw.ena = r[0] | r[1];
    fw.addr = (r[3:2] == 2'd0) ? ins[19:15] : ((r[3:2] == 2'd1) ? ins[24:20] : r[8:4]);
    fw.data = {$random(seed), $random(seed)};
  endtask

  task automatic show_mismatch(string name, logic [255:0] exp_v, logic [255:0] act_v);
    err_count++;
    $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
  endtask

  initial begin : drive
    inst_t       g_inst;
    xlen_t       g_pc;
    fwd_t        g_ex;
    fwd_t        g_mem;
    logic        g_load;
    logic        g_wb_ena;
    reg_addr_t   g_wb_addr;
    logic        held;
    logic [31:0] r;
    expect_t     e;
    reset = 1'b1;
    inst = '0;
    pc = '0;
    rf_rdata1 = '0;
    rf_rdata2 = '0;
    ex_fwd = '0;
    mem_fwd = '0;
    ex_load = 1'b0;
    wb_rd_ena = 1'b0;
    wb_rd_addr = '0;
    flush = 1'b0;
    g_ex = '0;
    held = 1'b0;
    for (int cyc = 0; cyc < n_reset + n_tests; cyc++) begin
      @(negedge clk);
      r = $random(seed);
      if (held) begin
        // the load has moved on to MEM and EX holds the bubble
        g_mem = g_ex;
        g_mem.data = {r, ~r};
        g_ex = '0;
        g_load = 1'b0;
      end else begin
        make_inst(g_inst);
        g_pc = {$random(seed), $random(seed)};
        g_pc[1:0] = 2'b00;
        make_fwd(g_inst, g_ex);
        make_fwd(g_inst, g_mem);
        g_load = (r[5:4] == 2'd0);
      end
      g_wb_ena = r[2];
      g_wb_addr = r[3] ? g_inst[19:15] : r[14:10];
      if (r[1:0] == 2'd0 && !held) begin
        g_ex.ena = 1'b0;
        g_mem.ena = 1'b0;
        g_wb_ena = 1'b0;
        g_load = 1'b0;
      end
      e = ref_decode(g_inst, g_pc, g_ex, g_mem, g_load, g_wb_ena, g_wb_addr, cyc < n_reset);
      reset = (cyc < n_reset);
      inst = g_inst;
      pc = g_pc;
      rf_rdata1 = rf_value(e.raddr1);
      rf_rdata2 = rf_value(e.raddr2);
      ex_fwd = g_ex;
      mem_fwd = g_mem;
      ex_load = g_load;
      wb_rd_ena = g_wb_ena;
      wb_rd_addr = g_wb_addr;
      flush = (r[9:6] == 4'd0);
      exp_q.push_back(e);
      if (e.stall) n_stall++;
      if (e.redirect) n_redirect++;
      held = e.stall;
    end
    repeat (2) @(negedge clk);
    #2;
    if (n_stall == 0 || n_redirect == 0) begin
      $display("stimulus never produced a load-use stall or a JALR redirect");
      err_count++;
    end
    $display("checks %0d, errors %0d, stalls %0d, redirects %0d",
             n_checks, err_count, n_stall, n_redirect);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // mid-cycle, after the falling-edge drive has settled
  initial begin : compare
    expect_t cur;
    id_ex_t  next_bundle;
    logic    next_valid;
    next_valid = 1'b0;
    next_bundle = empty_bundle();
    forever begin
      @(negedge clk);
      #1;
      if (next_valid) begin
        if (id_ex !== next_bundle) begin
          show_mismatch("id_ex_o", 256'(next_bundle), 256'(id_ex));
        end
        next_valid = 1'b0;
      end
      if (exp_q.size() != 0) begin
        cur = exp_q.pop_front();
        n_checks++;
        if (rf_raddr1 !== cur.raddr1) begin
          show_mismatch("rf_raddr1_o", 256'(cur.raddr1), 256'(rf_raddr1));
        end
        if (rf_raddr2 !== cur.raddr2) begin
          show_mismatch("rf_raddr2_o", 256'(cur.raddr2), 256'(rf_raddr2));
        end
        if (stall !== cur.stall) show_mismatch("stall_o", 256'(cur.stall), 256'(stall));
        if (jalr_redirect !== cur.redirect) begin
          show_mismatch("jalr_redirect_o", 256'(cur.redirect), 256'(jalr_redirect));
        end
        if (jalr_pc !== cur.jalr_pc) begin
          show_mismatch("jalr_pc_o", 256'(cur.jalr_pc), 256'(jalr_pc));
        end
        next_bundle = (reset || cur.stall || flush) ? empty_bundle() : cur.bundle;
        next_valid = 1'b1;
      end
    end
  end

  initial begin : watchdog
    #((n_tests * 4 * 2) + (n_reset * 4));
    $display("watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
hdl/id_pkg.sv
hdl/id_inst_decoder.sv
hdl/id_operand_sel.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
dv/tb_id_stage.sv

// ==== Makefile ====
TOP = tb_id_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TB PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log
